//--- Bender.yml
package:
  name: cps_mem

sources:
  - cps_mem_pkg.sv
  - cps_frac_cen.sv
  - cps_slot_port.sv
  - cps_slot_arbiter.sv
  - cps_rom_loader.sv
  - cps_mem_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_sdram_model.sv
      - tb_cps_mem.sv

//--- cps_frac_cen.sv
module cps_frac_cen import cps_mem_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    output logic cen_cpu
);

    logic [CEN_ACC_W-1:0] acc;
    logic [CEN_ACC_W-1:0] acc_sum;

    assign acc_sum = acc + CEN_ACC_W'(CEN_NUM);

    // Phase accumulator, wraps at CEN_DEN
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc     <= '0;
            cen_cpu <= 1'b0;
        end else if (acc_sum >= CEN_ACC_W'(CEN_DEN)) begin
            acc     <= acc_sum - CEN_ACC_W'(CEN_DEN);
            cen_cpu <= 1'b1;
        end else begin
            acc     <= acc_sum;
            cen_cpu <= 1'b0;
        end
    end

    // Ratio below one half keeps pulses apart
    a_cen_no_adjacent: assert property (
        @(posedge clk) disable iff (!arst_n)
        cen_cpu |=> !cen_cpu
    );

endmodule

//--- cps_mem_pkg.sv
package cps_mem_pkg;

    localparam int ADDR_W = 22;    // SDRAM word address

    // SDRAM word offsets, bank noted per line
    localparam logic [ADDR_W-1:0] SOUND_OFFSET = 22'h00_0000;   // Bank 0
    localparam logic [ADDR_W-1:0] ADPCM_OFFSET = 22'h01_0000;   // Bank 0
    localparam logic [ADDR_W-1:0] RAM_OFFSET   = 22'h20_0000;   // Bank 0
    localparam logic [ADDR_W-1:0] VRAM_OFFSET  = 22'h30_0000;   // Bank 0
    localparam logic [ADDR_W-1:0] GFX_OFFSET   = 22'h00_0000;   // Bank 2
    localparam logic [ADDR_W-1:0] CPU_OFFSET   = 22'h00_0000;   // Bank 1

    localparam logic [1:0] BANK_CPU = 2'd1;
    localparam logic [1:0] BANK_SND = 2'd0;
    localparam logic [1:0] BANK_GFX = 2'd2;

    // Region starts in the download byte stream, CPU code sits below sound
    localparam logic [24:0] DL_SND_START   = 25'h040_0000;
    localparam logic [24:0] DL_ADPCM_START = 25'h041_0000;
    localparam logic [24:0] DL_GFX_START   = 25'h045_0000;

    // 10 MHz CPU enable out of 48 MHz
    localparam int CEN_NUM   = 5;
    localparam int CEN_DEN   = 24;
    localparam int CEN_ACC_W = $clog2(CEN_DEN + CEN_NUM);

    localparam int NUM_SLOTS = 4;

    // Slot number doubles as priority, 0 wins
    typedef enum logic [1:0] {
        SLOT_MAIN_ROM = 2'd0,
        SLOT_MAIN_RAM = 2'd1,
        SLOT_GFX      = 2'd2,
        SLOT_SOUND    = 2'd3
    } slot_e;

    typedef struct packed {
        logic              cs;
        logic              we;
        logic              vram;      // Use the alternate offset
        logic [1:0]        wrmask;    // Active low
        logic [ADDR_W-1:0] addr;      // Relative to the slot region
        logic [15:0]       wdata;
    } slot_req_t;

    typedef struct packed {
        logic        ok;
        logic [31:0] data;
    } slot_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;      // Absolute word address
        logic [1:0]        bank;
        logic              rnw;
        logic [1:0]        wrmask;
        logic [15:0]       wdata;
    } sdram_cmd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [1:0]        bank;
        logic [1:0]        mask;      // Active low byte select
        logic [7:0]        data;
    } prog_cmd_t;

endpackage

//--- cps_mem_top.f
cps_mem_pkg.sv
cps_frac_cen.sv
cps_slot_port.sv
cps_slot_arbiter.sv
cps_rom_loader.sv
cps_mem_top.sv
tb_clk_gen.sv
tb_sdram_model.sv
tb_cps_mem.sv

//--- cps_mem_top.sv
module cps_mem_top import cps_mem_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    output logic        cen_cpu,
    input  slot_req_t   slot_req [NUM_SLOTS],
    output slot_rsp_t   slot_rsp [NUM_SLOTS],
    input  logic        downloading,
    output logic        sdram_req,
    input  logic        sdram_ack,
    output sdram_cmd_t  sdram_cmd,
    input  logic        data_rdy,
    input  logic [31:0] data_read,
    output logic        refresh_en,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output prog_cmd_t   prog,
    output logic        prog_we
);

    logic [NUM_SLOTS-1:0] pending;
    logic [NUM_SLOTS-1:0] done;
    sdram_cmd_t           slot_cmd [NUM_SLOTS];
    logic [31:0]          rd_data;

    cps_frac_cen u_cen (
        .clk     (clk),
        .arst_n  (arst_n),
        .cen_cpu (cen_cpu)
    );

    // Main CPU ROM in bank 1
    cps_slot_port #(.OFFSET(CPU_OFFSET), .ALT_OFFSET(CPU_OFFSET), .BANK(BANK_CPU)) u_slot_rom (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (slot_req[SLOT_MAIN_ROM]),
        .rsp     (slot_rsp[SLOT_MAIN_ROM]),
        .pending (pending[SLOT_MAIN_ROM]),
        .cmd     (slot_cmd[SLOT_MAIN_ROM]),
        .done    (done[SLOT_MAIN_ROM]),
        .rd_data (rd_data)
    );

    // Work RAM, or VRAM when vram is set
    cps_slot_port #(.OFFSET(RAM_OFFSET), .ALT_OFFSET(VRAM_OFFSET), .BANK(BANK_SND)) u_slot_ram (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (slot_req[SLOT_MAIN_RAM]),
        .rsp     (slot_rsp[SLOT_MAIN_RAM]),
        .pending (pending[SLOT_MAIN_RAM]),
        .cmd     (slot_cmd[SLOT_MAIN_RAM]),
        .done    (done[SLOT_MAIN_RAM]),
        .rd_data (rd_data)
    );

    cps_slot_port #(.OFFSET(GFX_OFFSET), .ALT_OFFSET(GFX_OFFSET), .BANK(BANK_GFX)) u_slot_gfx (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (slot_req[SLOT_GFX]),
        .rsp     (slot_rsp[SLOT_GFX]),
        .pending (pending[SLOT_GFX]),
        .cmd     (slot_cmd[SLOT_GFX]),
        .done    (done[SLOT_GFX]),
        .rd_data (rd_data)
    );

    cps_slot_port #(.OFFSET(SOUND_OFFSET), .ALT_OFFSET(SOUND_OFFSET), .BANK(BANK_SND)) u_slot_snd (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (slot_req[SLOT_SOUND]),
        .rsp     (slot_rsp[SLOT_SOUND]),
        .pending (pending[SLOT_SOUND]),
        .cmd     (slot_cmd[SLOT_SOUND]),
        .done    (done[SLOT_SOUND]),
        .rd_data (rd_data)
    );

    cps_slot_arbiter u_arbiter (
        .clk         (clk),
        .arst_n      (arst_n),
        .pending     (pending),
        .slot_cmd    (slot_cmd),
        .done        (done),
        .rd_data     (rd_data),
        .downloading (downloading),
        .sdram_req   (sdram_req),
        .sdram_ack   (sdram_ack),
        .sdram_cmd   (sdram_cmd),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .refresh_en  (refresh_en)
    );

    // Download path bypasses the arbiter
    cps_rom_loader u_loader (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .prog        (prog),
        .prog_we     (prog_we),
        .sdram_ack   (sdram_ack)
    );

endmodule

//--- cps_rom_loader.sv
module cps_rom_loader import cps_mem_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output prog_cmd_t   prog,
    output logic        prog_we,
    input  logic        sdram_ack
);

    typedef enum logic [1:0] {
        RGN_CPU,
        RGN_SND,
        RGN_ADPCM,
        RGN_GFX
    } region_e;

    region_e           region;
    logic [24:0]       rgn_start;
    logic [ADDR_W-1:0] rgn_offset;
    logic [1:0]        rgn_bank;
    logic [24:0]       rel_addr;
    logic              load;

    always_comb begin
        if (ioctl_addr < DL_SND_START) begin
            region = RGN_CPU;
        end else if (ioctl_addr < DL_ADPCM_START) begin
            region = RGN_SND;
        end else if (ioctl_addr < DL_GFX_START) begin
            region = RGN_ADPCM;
        end else begin
            region = RGN_GFX;
        end
    end

    always_comb begin
        case (region)
            RGN_CPU: begin
                rgn_start  = '0;
                rgn_offset = CPU_OFFSET;
                rgn_bank   = BANK_CPU;
            end
            RGN_SND: begin
                rgn_start  = DL_SND_START;
                rgn_offset = SOUND_OFFSET;
                rgn_bank   = BANK_SND;
            end
            RGN_ADPCM: begin
                rgn_start  = DL_ADPCM_START;
                rgn_offset = ADPCM_OFFSET;
                rgn_bank   = BANK_SND;    // Shares the sound bank
            end
            default: begin
                rgn_start  = DL_GFX_START;
                rgn_offset = GFX_OFFSET;
                rgn_bank   = BANK_GFX;
            end
        endcase
    end

    assign rel_addr = ioctl_addr - rgn_start;
    assign load     = downloading & ioctl_wr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
        end else if (load) begin
            prog_we <= 1'b1;
        end else if (sdram_ack) begin
            prog_we <= 1'b0;
        end
    end

    // Two bytes per SDRAM word
    always_ff @(posedge clk) begin
        if (load) begin
            prog.addr <= rel_addr[ADDR_W:1] + rgn_offset;
            prog.bank <= rgn_bank;
            prog.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            prog.data <= ioctl_data;
        end
    end

    // A new byte must not overwrite a write still waiting for its ack
    a_prog_we_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        prog_we && !sdram_ack |=> prog_we && $stable(prog)
    );

endmodule

//--- cps_slot_arbiter.sv
module cps_slot_arbiter import cps_mem_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [NUM_SLOTS-1:0] pending,
    input  sdram_cmd_t           slot_cmd [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0] done,
    output logic [31:0]          rd_data,
    input  logic                 downloading,
    output logic                 sdram_req,
    input  logic                 sdram_ack,
    output sdram_cmd_t           sdram_cmd,
    input  logic                 data_rdy,
    input  logic [31:0]          data_read,
    output logic                 refresh_en
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,     // Waiting for sdram_ack
        ARB_WAIT     // Waiting for data_rdy
    } arb_state_e;

    arb_state_e state;
    slot_e      gnt;
    slot_e      pick;
    logic       grant;

    // Lowest pending slot number wins
    always_comb begin
        pick = SLOT_SOUND;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                pick = slot_e'(i);
            end
        end
    end

    assign grant = (state == ARB_IDLE) && !downloading && |pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ARB_IDLE;
            gnt   <= SLOT_MAIN_ROM;
        end else begin
            unique case (state)
                ARB_IDLE: begin
                    if (grant) begin
                        state <= ARB_REQ;
                        gnt   <= pick;
                    end
                end
                ARB_REQ: begin
                    if (sdram_ack) begin
                        state <= ARB_WAIT;
                    end
                end
                ARB_WAIT: begin
                    if (data_rdy) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            sdram_cmd <= slot_cmd[pick];   // Held for the whole access
        end
    end

    always_comb begin
        done = '0;
        if (state == ARB_WAIT && data_rdy) begin
            done[gnt] = 1'b1;
        end
    end

    assign rd_data    = data_read;
    assign sdram_req  = (state == ARB_REQ);
    assign refresh_en = (state == ARB_IDLE);   // Port free for refresh

    a_cmd_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        sdram_req |=> $stable(sdram_cmd)
    );

    // Download owns the SDRAM
    a_no_req_in_dl: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(sdram_req) |-> !$past(downloading)
    );

endmodule

//--- cps_slot_port.sv
module cps_slot_port import cps_mem_pkg::*; #(
    parameter logic [ADDR_W-1:0] OFFSET     = '0,
    parameter logic [ADDR_W-1:0] ALT_OFFSET = '0,
    parameter logic [1:0]        BANK       = 2'd0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  slot_req_t   req,
    output slot_rsp_t   rsp,
    output logic        pending,
    output sdram_cmd_t  cmd,
    input  logic        done,
    input  logic [31:0] rd_data
);

    logic        ok_q;
    logic [31:0] data_q;
    logic        start;

    // New request only once the previous ok is gone
    assign start = req.cs & ~pending & ~ok_q;

    assign rsp.ok   = ok_q;
    assign rsp.data = data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            ok_q    <= 1'b0;
        end else begin
            if (done) begin
                pending <= 1'b0;
            end else if (start) begin
                pending <= 1'b1;
            end
            if (done) begin
                ok_q <= 1'b1;
            end else if (!req.cs) begin
                ok_q <= 1'b0;      // Last phase of the handshake
            end
        end
    end

    // Region mapping happens once, at the start of the access
    always_ff @(posedge clk) begin
        if (start) begin
            cmd.addr   <= req.addr + (req.vram ? ALT_OFFSET : OFFSET);
            cmd.bank   <= BANK;
            cmd.rnw    <= ~req.we;
            cmd.wrmask <= req.wrmask;
            cmd.wdata  <= req.wdata;
        end
        if (done) begin
            data_q <= rd_data;
        end
    end

    // Requester holds its fields until it gets ok
    a_req_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        req.cs && !rsp.ok |=> !req.cs
            || $stable({req.we, req.vram, req.wrmask, req.addr, req.wdata})
    );

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;    // 10 ns period
        end
    end

    // Held for 10 cycles, let go on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (10) @(negedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- tb_cps_mem.sv
module tb_cps_mem import cps_mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk;
    logic                 arst_n;
    logic                 cen_cpu;
    slot_req_t            slot_req [NUM_SLOTS];
    slot_rsp_t            slot_rsp [NUM_SLOTS];
    logic                 downloading;
    logic                 sdram_req;
    logic                 sdram_ack;
    sdram_cmd_t           sdram_cmd;
    logic                 data_rdy;
    logic [31:0]          data_read;
    logic                 refresh_en;
    logic [24:0]          ioctl_addr;
    logic [7:0]           ioctl_data;
    logic                 ioctl_wr;
    prog_cmd_t            prog;
    logic                 prog_we;
    sdram_cmd_t           last_wr;
    logic [NUM_SLOTS-1:0] ok_vec;

    sdram_cmd_t  exp_cmd;                 // Next command the arbiter must issue
    logic [31:0] exp_data [NUM_SLOTS];
    prog_cmd_t   exp_prog;
    int          errors    = 0;
    int          accesses  = 0;
    int          dl_writes = 0;
    int          cen_count = 0;
    int          cyc       = 0;           // Cycles since reset release

    tb_clk_gen u_clk (.clk, .arst_n);

    cps_mem_top u_dut (.*);

    tb_sdram_model u_sdram (
        .clk, .arst_n, .sdram_req, .prog_we, .sdram_cmd,
        .sdram_ack, .data_rdy, .data_read, .last_wr
    );

    // Memory map per slot
    function automatic sdram_cmd_t map_slot(input slot_e s, input slot_req_t r);
        sdram_cmd_t c;
        c.rnw    = !r.we;
        c.wrmask = r.wrmask;
        c.wdata  = r.wdata;
        case (s)
            SLOT_MAIN_ROM: begin
                c.addr = r.addr + CPU_OFFSET;
                c.bank = BANK_CPU;
            end
            SLOT_MAIN_RAM: begin
                c.addr = r.addr + (r.vram ? VRAM_OFFSET : RAM_OFFSET);
                c.bank = BANK_SND;
            end
            SLOT_GFX: begin
                c.addr = r.addr + GFX_OFFSET;
                c.bank = BANK_GFX;
            end
            default: begin
                c.addr = r.addr + SOUND_OFFSET;
                c.bank = BANK_SND;
            end
        endcase
        return c;
    endfunction

    // Download byte to SDRAM word by region
    function automatic prog_cmd_t map_byte(input logic [24:0] a, input logic [7:0] d);
        prog_cmd_t         p;
        logic [24:0]       start;
        logic [ADDR_W-1:0] off;
        if (a >= DL_GFX_START) begin
            start  = DL_GFX_START;
            off    = GFX_OFFSET;
            p.bank = BANK_GFX;
        end else if (a >= DL_ADPCM_START) begin
            start  = DL_ADPCM_START;
            off    = ADPCM_OFFSET;
            p.bank = BANK_SND;
        end else if (a >= DL_SND_START) begin
            start  = DL_SND_START;
            off    = SOUND_OFFSET;
            p.bank = BANK_SND;
        end else begin
            start  = '0;
            off    = CPU_OFFSET;
            p.bank = BANK_CPU;
        end
        p.addr = ADDR_W'((a - start) >> 1) + off;
        p.mask = a[0] ? 2'b01 : 2'b10;   // Odd byte is the high one
        p.data = d;
        return p;
    endfunction

    function automatic logic [31:0] model_word(input logic [ADDR_W-1:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    task automatic start_req(input slot_e s, input logic we, input logic vram,
                             input logic [ADDR_W-1:0] a, input logic [15:0] wd);
        slot_req_t  r;
        sdram_cmd_t c;
        r.cs     = 1'b1;
        r.we     = we;
        r.vram   = vram;
        r.wrmask = we ? 2'b10 : 2'b11;   // Low byte only on writes
        r.addr   = a;
        r.wdata  = wd;
        c = map_slot(s, r);
        exp_data[s] = model_word(c.addr);
        slot_req[s] = r;
    endtask

    task automatic expect_cmd(input slot_e s);
        exp_cmd = map_slot(s, slot_req[s]);
    endtask

    task automatic finish_req(input slot_e s);
        int n;
        n = 0;
        while (!slot_rsp[s].ok && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!slot_rsp[s].ok) begin
            errors++;
            $display("Slot %0d never returned ok", s);
        end
        slot_req[s].cs = 1'b0;
        @(negedge clk);                  // ok is gone by now
        accesses++;
    endtask

    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        int n;
        n = 0;
        exp_prog   = map_byte(a, d);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        while (prog_we && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (prog_we) begin
            errors++;
            $display("prog_we was never acknowledged");
        end
        dl_writes++;
    endtask

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        assign ok_vec[i] = slot_rsp[i].ok;

        a_rd_data: assert property (@(posedge clk) disable iff (!arst_n)
            $rose(slot_rsp[i].ok) |-> slot_rsp[i].data == exp_data[i])
        else begin
            errors++;
            $display("Error: slot_rsp[%0d].data = %h, expected %h", i,
                     $sampled(slot_rsp[i].data), $sampled(exp_data[i]));
        end

        a_ok_release: assert property (@(posedge clk) disable iff (!arst_n)
            !slot_req[i].cs && slot_rsp[i].ok |=> !slot_rsp[i].ok)
        else begin
            errors++;
            $display("Error: slot_rsp[%0d].ok = %h after cs fell, expected %h", i, 1'b1, 1'b0);
        end
    end

    a_reset_state: assert property (@(posedge clk) $rose(arst_n) |->
        !sdram_req && !prog_we && !cen_cpu && refresh_en && ok_vec == '0)
    else begin
        errors++;
        $display(
            "Error: sdram_req=%h prog_we=%h cen_cpu=%h refresh_en=%h ok=%h, expected 0 0 0 1 0",
            $sampled(sdram_req), $sampled(prog_we), $sampled(cen_cpu),
            $sampled(refresh_en), $sampled(ok_vec));
    end

    a_cen_count: assert property (@(posedge clk) cyc == 2400 |-> cen_count == 500)
    else begin
        errors++;
        $display("Error: cen_cpu pulses = %h, expected %h", $sampled(cen_count), 500);
    end

    a_cen_apart: assert property (@(posedge clk) disable iff (!arst_n) cen_cpu |=> !cen_cpu)
    else begin
        errors++;
        $display("Error: cen_cpu = %h on adjacent clocks, expected %h", 1'b1, 1'b0);
    end

    a_cmd_map: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(sdram_req) |-> sdram_cmd == exp_cmd)
    else begin
        errors++;
        $display("Error: sdram_cmd = %h, expected %h", $sampled(sdram_cmd), $sampled(exp_cmd));
    end

    // Port is busy while a request is out
    a_refresh_busy: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_req |-> !refresh_en)
    else begin
        errors++;
        $display("Error: refresh_en = %h while sdram_req is high, expected %h", 1'b1, 1'b0);
    end

    a_wr_kept: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(slot_rsp[SLOT_MAIN_RAM].ok) && !exp_cmd.rnw |-> last_wr == exp_cmd)
    else begin
        errors++;
        $display("Error: last_wr = %h, expected %h", $sampled(last_wr), $sampled(exp_cmd));
    end

    a_dl_no_req: assert property (@(posedge clk) disable iff (!arst_n)
        downloading |-> !sdram_req)
    else begin
        errors++;
        $display("Error: sdram_req = %h while downloading, expected %h", 1'b1, 1'b0);
    end

    a_prog_map: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(prog_we) |-> prog == exp_prog)
    else begin
        errors++;
        $display("Error: prog = %h, expected %h", $sampled(prog), $sampled(exp_prog));
    end

    // Cycle count, enable tally and run limit
    always @(negedge clk) begin
        if (arst_n) begin
            cyc <= cyc + 1;
            if (cyc < 2400 && cen_cpu) begin
                cen_count <= cen_count + 1;
            end
            if (cyc == 4000) begin
                $display("Timeout: the run did not finish within 4000 cycles");
                $display("%0d accesses, %0d download writes, %0d errors",
                         accesses, dl_writes, errors);
                $display("Test FAILED");
                $finish;
            end
        end
    end

    initial begin
        foreach (slot_req[i]) begin
            slot_req[i] = '0;
            exp_data[i] = '0;
        end
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        exp_cmd     = '0;
        exp_prog    = '0;
        @(posedge arst_n);
        @(negedge clk);

        for (int i = 0; i < NUM_SLOTS; i++) begin      // One read per slot
            start_req(slot_e'(i), 1'b0, 1'b0, 22'h01_2340 + 22'(i * 'h111), '0);
            expect_cmd(slot_e'(i));
            finish_req(slot_e'(i));
        end

        start_req(SLOT_MAIN_RAM, 1'b1, 1'b1, 22'h00_0abc, 16'h5a3c);   // VRAM write
        expect_cmd(SLOT_MAIN_RAM);
        finish_req(SLOT_MAIN_RAM);
        start_req(SLOT_MAIN_RAM, 1'b1, 1'b0, 22'h00_0123, 16'hc3a5);   // Work RAM write
        expect_cmd(SLOT_MAIN_RAM);
        finish_req(SLOT_MAIN_RAM);

        // Same edge, ROM must win
        start_req(SLOT_MAIN_ROM, 1'b0, 1'b0, 22'h00_3000, '0);
        start_req(SLOT_GFX, 1'b0, 1'b0, 22'h00_0777, '0);
        expect_cmd(SLOT_MAIN_ROM);
        finish_req(SLOT_MAIN_ROM);
        expect_cmd(SLOT_GFX);
        finish_req(SLOT_GFX);

        downloading = 1'b1;
        @(negedge clk);
        start_req(SLOT_SOUND, 1'b0, 1'b0, 22'h00_0456, '0);          // Held off by download
        expect_cmd(SLOT_SOUND);
        load_byte(25'h000_0100, 8'h11);
        load_byte(25'h000_0203, 8'h22);
        load_byte(DL_SND_START + 25'h100, 8'h33);
        load_byte(DL_SND_START + 25'h203, 8'h44);
        load_byte(DL_ADPCM_START + 25'h100, 8'h55);
        load_byte(DL_ADPCM_START + 25'h203, 8'h66);
        load_byte(DL_GFX_START + 25'h100, 8'h77);
        load_byte(DL_GFX_START + 25'h203, 8'h88);
        downloading = 1'b0;
        finish_req(SLOT_SOUND);

        wait (cyc > 2400);             // End of the enable window
        @(negedge clk);
        $display("%0d accesses, %0d download writes, %0d cen pulses, %0d errors",
                 accesses, dl_writes, cen_count, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tb_sdram_model.sv
module tb_sdram_model import cps_mem_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        sdram_req,
    input  logic        prog_we,
    input  sdram_cmd_t  sdram_cmd,
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [31:0] data_read,
    output sdram_cmd_t  last_wr
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {
        M_IDLE,
        M_ACK,     // Counting down to sdram_ack
        M_DATA     // Counting down to data_rdy
    } model_state_e;

    model_state_e      state;
    logic [31:0]       lfsr;
    logic [1:0]        cnt;
    logic [ADDR_W-1:0] addr_q;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Everything toggles on the falling edge
    initial begin
        logic [31:0] s;
        logic [1:0]  d;
        state     = M_IDLE;
        lfsr      = 32'h5cf0;
        cnt       = '0;
        addr_q    = '0;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        last_wr   = '0;
        forever begin
            @(negedge clk);
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (!arst_n) begin
                state <= M_IDLE;
                lfsr  <= 32'h5cf0;
            end else begin
                case (state)
                    M_IDLE: begin
                        if (sdram_req || prog_we) begin
                            d[0]  = lfsr[0];            // Two bits, one step each
                            s     = lfsr_step(lfsr);
                            d[1]  = s[0];
                            lfsr  <= lfsr_step(s);
                            cnt   <= d % 2'd3;          // Ack after 1 to 3 cycles
                            state <= M_ACK;
                        end
                    end
                    M_ACK: begin
                        if (cnt == 2'd0) begin
                            sdram_ack <= 1'b1;
                            addr_q    <= sdram_cmd.addr;
                            if (sdram_req && !sdram_cmd.rnw) begin
                                last_wr <= sdram_cmd;
                            end
                            cnt   <= 2'd1;
                            state <= M_DATA;
                        end else begin
                            cnt <= cnt - 2'd1;
                        end
                    end
                    default: begin
                        if (cnt == 2'd0) begin
                            data_rdy  <= 1'b1;
                            data_read <= {~addr_q[15:0], addr_q[15:0]};
                            state     <= M_IDLE;
                        end else begin
                            cnt <= cnt - 2'd1;
                        end
                    end
                endcase
            end
        end
    end

endmodule
